// ==== hdl/mvm_num_pkg.sv ====
// Numeric format package: Q8.8 element and wide accumulator definitions
`default_nettype none

package mvm_num_pkg;

    // Element format, signed Q8.8
    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;

    // Exact product of two elements
    localparam int PROD_W = 2 * DATA_W;

    // Four products summed need two growth bits, two more kept as margin
    localparam int ACC_W = PROD_W + 4;

    // Matrix is DIM x DIM, vector has DIM elements
    localparam int DIM = 4;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // Saturation limits of one element
    localparam data_t DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam data_t DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

endpackage

`default_nettype wire

// ==== hdl/mvm_ctrl_pkg.sv ====
// Control package: sequencer states, lane split and column step type
`default_nettype none

package mvm_ctrl_pkg;

    // Sequencer is either waiting for input or stepping columns
    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_t;

    // Two lanes of two rows each cover the 4x4 matrix
    localparam int N_LANES       = 2;
    localparam int ROWS_PER_LANE = 2;

    // Column index within one pass
    typedef logic [1:0] step_t;

    // Final column of a pass
    localparam step_t LAST_STEP = 2'd3;

endpackage

`default_nettype wire

// ==== hdl/mvm_lane_if.sv ====
// Lane interface: column operands into one row-pair lane and its results out
`default_nettype none
`timescale 1ns/100ps

interface mvm_lane_if;

    import mvm_num_pkg::*;
    import mvm_ctrl_pkg::*;

    // Column operand, one per cycle while step_vld is high
    logic  step_vld;
    step_t step;
    data_t x_elem;
    data_t a_elem [ROWS_PER_LANE];

    // Saturated row results of a finished pass
    data_t res [ROWS_PER_LANE];
    logic  res_vld;

    modport seq (
        output step_vld,
        output step,
        output x_elem,
        output a_elem
    );

    modport mac (
        input  step_vld,
        input  step,
        input  x_elem,
        input  a_elem,
        output res,
        output res_vld
    );

    modport merge (
        input res,
        input res_vld
    );

endinterface

`default_nettype wire

// ==== hdl/mvm_sequencer.sv ====
// Sequencer: captures matrix and vector, then feeds one column per cycle to both lanes
`default_nettype none
`timescale 1ns/100ps

module mvm_sequencer (
    input  wire                 clk,
    input  wire                 rstn,

    // Operands from the top level
    input  mvm_num_pkg::data_t  i_a [mvm_num_pkg::DIM][mvm_num_pkg::DIM],
    input  mvm_num_pkg::data_t  i_x [mvm_num_pkg::DIM],
    input  wire                 i_dv,
    output logic                o_ready,

    // Column operands to the lanes
    mvm_lane_if.seq             lane0,
    mvm_lane_if.seq             lane1
);

    import mvm_num_pkg::*;
    import mvm_ctrl_pkg::*;

    seq_state_t state;
    step_t      step_cnt;
    logic       accept;

    // Captured operands
    data_t      a_r [DIM][DIM];
    data_t      x_r [DIM];

    // Ready only while waiting for work
    assign o_ready = (state == SEQ_IDLE);
    assign accept  = i_dv && o_ready;

    // State and column counter
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state    <= SEQ_IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (accept) begin
                        state    <= SEQ_RUN;
                        step_cnt <= '0;
                    end
                end

                SEQ_RUN: begin
                    step_cnt <= step_cnt + 1'b1;
                    // Back to idle once the last column has gone out
                    if (step_cnt == LAST_STEP) begin
                        state <= SEQ_IDLE;
                    end
                end

                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // Operands are held for the whole pass
    always_ff @(posedge clk) begin
        if (accept) begin
            a_r <= i_a;
            x_r <= i_x;
        end
    end

    // Same column and vector element go to both lanes
    assign lane0.step_vld = (state == SEQ_RUN);
    assign lane0.step     = step_cnt;
    assign lane0.x_elem   = x_r[step_cnt];

    assign lane1.step_vld = (state == SEQ_RUN);
    assign lane1.step     = step_cnt;
    assign lane1.x_elem   = x_r[step_cnt];

    // Lane 0 takes the upper row pair, lane 1 the lower
    always_comb begin
        for (int r = 0; r < ROWS_PER_LANE; r++) begin
            lane0.a_elem[r] = a_r[r][step_cnt];
            lane1.a_elem[r] = a_r[ROWS_PER_LANE + r][step_cnt];
        end
    end

    // An accepted vector gives exactly four column steps with ready low,
    // then ready comes back with the lanes quiet
    a_run_window: assert property (
        @(posedge clk) disable iff (!rstn)
        accept |=> (lane0.step_vld && lane1.step_vld && !o_ready) [*4]
                   ##1 (o_ready && !lane0.step_vld && !lane1.step_vld)
    );

endmodule

`default_nettype wire

// ==== hdl/mvm_row_pair_mac.sv ====
// Row-pair MAC lane: accumulates two matrix rows against the vector, then shifts and saturates
`default_nettype none
`timescale 1ns/100ps

module mvm_row_pair_mac (
    input  wire     clk,
    input  wire     rstn,

    mvm_lane_if.mac lane
);

    import mvm_num_pkg::*;
    import mvm_ctrl_pkg::*;

    // Exact products of this column
    logic signed [PROD_W-1:0] prod [ROWS_PER_LANE];

    // Running row sums
    acc_t acc [ROWS_PER_LANE];

    // Last column was folded in at the previous edge
    logic last_q;

    // Drop the fraction bits, rounding toward minus infinity, and clamp
    function automatic data_t shift_sat(input acc_t sum);
        acc_t shifted;
        shifted = sum >>> FRAC_W;
        if (shifted > acc_t'(DATA_MAX)) begin
            return DATA_MAX;
        end else if (shifted < acc_t'(DATA_MIN)) begin
            return DATA_MIN;
        end else begin
            return data_t'(shifted);
        end
    endfunction

    always_comb begin
        for (int r = 0; r < ROWS_PER_LANE; r++) begin
            prod[r] = lane.a_elem[r] * lane.x_elem;
        end
    end

    // Step 0 restarts the sum
    always_ff @(posedge clk) begin
        if (lane.step_vld) begin
            for (int r = 0; r < ROWS_PER_LANE; r++) begin
                if (lane.step == '0) begin
                    acc[r] <= acc_t'(prod[r]);
                end else begin
                    acc[r] <= acc[r] + acc_t'(prod[r]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            last_q       <= 1'b0;
            lane.res_vld <= 1'b0;
        end else begin
            last_q       <= lane.step_vld && (lane.step == LAST_STEP);
            lane.res_vld <= last_q;
        end
    end

    // Results taken one cycle after the final accumulate
    always_ff @(posedge clk) begin
        if (last_q) begin
            for (int r = 0; r < ROWS_PER_LANE; r++) begin
                lane.res[r] <= shift_sat(acc[r]);
            end
        end
    end

    // A pass starts at column 0
    a_step_start: assert property (
        @(posedge clk) disable iff (!rstn)
        $rose(lane.step_vld) |-> (lane.step == '0)
    );

    // and walks the columns in order with no gaps
    a_step_order: assert property (
        @(posedge clk) disable iff (!rstn)
        (lane.step_vld && (lane.step != LAST_STEP))
            |=> (lane.step_vld && (lane.step == step_t'($past(lane.step) + 1'b1)))
    );

endmodule

`default_nettype wire

// ==== hdl/mvm_result_merge.sv ====
// Result merger: joins both lanes into the output vector with a one-cycle valid
`default_nettype none
`timescale 1ns/100ps

module mvm_result_merge (
    input  wire                 clk,
    input  wire                 rstn,

    // Finished row pairs from the lanes
    mvm_lane_if.merge           lane0,
    mvm_lane_if.merge           lane1,

    // Output vector and its strobe
    output mvm_num_pkg::data_t  o_y [mvm_num_pkg::DIM],
    output logic                o_dv
);

    import mvm_ctrl_pkg::*;

    logic both_vld;

    assign both_vld = lane0.res_vld && lane1.res_vld;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_dv <= 1'b0;
            for (int i = 0; i < 2 * ROWS_PER_LANE; i++) begin
                o_y[i] <= '0;
            end
        end else begin
            o_dv <= both_vld;
            // Rows 0-1 from lane 0, rows 2-3 from lane 1
            if (both_vld) begin
                for (int r = 0; r < ROWS_PER_LANE; r++) begin
                    o_y[r]                 <= lane0.res[r];
                    o_y[ROWS_PER_LANE + r] <= lane1.res[r];
                end
            end
        end
    end

    // Lanes run in lock step, so a lone pulse means a lost result
    a_lanes_aligned: assert property (
        @(posedge clk) disable iff (!rstn)
        lane0.res_vld == lane1.res_vld
    );

endmodule

`default_nettype wire

// ==== hdl/mat_vec_mul_top.sv ====
// Matrix-vector multiplier top: 4x4 Q8.8 matrix times 4-element vector
`default_nettype none
`timescale 1ns/100ps

module mat_vec_mul_top (
    input  wire                 clk,
    input  wire                 rstn,

    // Input matrix and vector, taken when i_dv and o_ready are high
    input  mvm_num_pkg::data_t  i_a [mvm_num_pkg::DIM][mvm_num_pkg::DIM],
    input  mvm_num_pkg::data_t  i_x [mvm_num_pkg::DIM],
    input  wire                 i_dv,

    // Result vector, valid for one cycle with o_dv
    output mvm_num_pkg::data_t  o_y [mvm_num_pkg::DIM],
    output logic                o_dv,
    output logic                o_ready
);

    import mvm_ctrl_pkg::*;

    // One link per row-pair lane
    mvm_lane_if lane_if [N_LANES] ();

    // Column stepping and operand broadcast
    mvm_sequencer sequencer_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_a     (i_a),
        .i_x     (i_x),
        .i_dv    (i_dv),
        .o_ready (o_ready),
        .lane0   (lane_if[0]),
        .lane1   (lane_if[1])
    );

    // Lanes work side by side on their row pairs
    for (genvar g = 0; g < N_LANES; g++) begin : g_lane
        mvm_row_pair_mac mac_i (
            .clk  (clk),
            .rstn (rstn),
            .lane (lane_if[g])
        );
    end

    // Output register and strobe
    mvm_result_merge merge_i (
        .clk   (clk),
        .rstn  (rstn),
        .lane0 (lane_if[0]),
        .lane1 (lane_if[1]),
        .o_y   (o_y),
        .o_dv  (o_dv)
    );

endmodule

`default_nettype wire

// ==== dv/tb_mvm_util.svh ====
// Testbench helpers for the matrix-vector multiplier: LFSR step, reference model, stimulus entry
`ifndef TB_MVM_UTIL_SVH
`define TB_MVM_UTIL_SVH

// Operand shapes, element 0 in the low bits
typedef data_t [DIM-1:0]          vec_t;
typedef data_t [DIM-1:0][DIM-1:0] mat_t;

// One table row: matrix, vector and whether i_dv stays high into the next entry
typedef struct packed {
    mat_t a;
    vec_t x;
    logic hold_dv;
} stim_entry_t;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// y = A * x in Q8.8 with an exact sum, floor shift and clamp
function automatic vec_t matvec_ref(input mat_t a, input vec_t x);
    vec_t   y;
    longint sum;
    longint q;
    for (int r = 0; r < DIM; r++) begin
        sum = 0;
        for (int c = 0; c < DIM; c++) begin
            sum += longint'(signed'(a[r][c])) * longint'(signed'(x[c]));
        end
        // Arithmetic shift rounds toward minus infinity
        q = sum >>> FRAC_W;
        if (q > 32767) begin
            y[r] = 16'sh7fff;
        end else if (q < -32768) begin
            y[r] = 16'sh8000;
        end else begin
            y[r] = data_t'(q);
        end
    end
    return y;
endfunction

`endif

// ==== dv/tb_mat_vec_mul.sv ====
// Matrix-vector multiplier testbench: table-driven stimulus with value and latency checks
`default_nettype none
`timescale 1ns/100ps

module tb_mat_vec_mul;

    import mvm_num_pkg::*;

    `include "tb_mvm_util.svh"

    localparam int          N_DIRECTED  = 7;
    localparam int          N_RANDOM    = 20;
    localparam int          N_ENTRIES   = N_DIRECTED + N_RANDOM;
    localparam int          LATENCY     = 6;
    localparam int          ACCEPT_GAP  = 5;
    localparam int          TIMEOUT_CYC = N_ENTRIES * 8 + 20;
    localparam logic [31:0] LFSR_SEED   = 32'h6a4a_afac;

    logic  clk;
    logic  rstn;
    data_t i_a [DIM][DIM];
    data_t i_x [DIM];
    logic  i_dv;
    data_t o_y [DIM];
    logic  o_dv;
    logic  o_ready;

    // Stimulus table and its expected results
    stim_entry_t tab [N_ENTRIES];
    vec_t        exp_tab [N_ENTRIES];

    // Results owed by the DUT, oldest first
    vec_t        exp_q [$];
    int          due_q [$];

    logic [31:0] lfsr      = LFSR_SEED;
    int          edge_cnt  = 0;
    int          acc_cnt   = 0;
    int          done_cnt  = 0;
    int          last_acc  = 0;
    int          val_err   = 0;
    int          time_err  = 0;
    int          proto_err = 0;

    mat_vec_mul_top mat_vec_mul_top_i (
        .clk     (clk),
        .rstn    (rstn),
        .i_a     (i_a),
        .i_x     (i_x),
        .i_dv    (i_dv),
        .o_y     (o_y),
        .o_dv    (o_dv),
        .o_ready (o_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Cycle count, also used for latency checks
    always @(posedge clk) begin
        edge_cnt <= edge_cnt + 1;
        if (edge_cnt >= TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Test failed");
            $finish;
        end
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // Signed element from w random bits
    function automatic data_t rand_elem(input int w);
        logic [31:0] b;
        b = rand_bits(w);
        return data_t'(signed'(b << (32 - w)) >>> (32 - w));
    endfunction

    function automatic void set_row(input int idx, input int r,
                                    input data_t c0, input data_t c1,
                                    input data_t c2, input data_t c3);
        tab[idx].a[r] = {c3, c2, c1, c0};
    endfunction

    function automatic void set_vec(input int idx, input data_t x0, input data_t x1,
                                    input data_t x2, input data_t x3, input logic hold);
        tab[idx].x       = {x3, x2, x1, x0};
        tab[idx].hold_dv = hold;
    endfunction

    function automatic void build_table();
        // Identity, y must equal x
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                tab[0].a[r][c] = (r == c) ? 16'h0100 : 16'h0000;
            end
        end
        set_vec(0, 16'h0100, 16'hfd80, 16'h00c0, 16'h0300, 1'b0);
        // Mixed signs with odd fractions
        set_row(1, 0, 16'h0181, 16'hff3f, 16'h0023, 16'hfe01);
        set_row(1, 1, 16'hfc80, 16'h0267, 16'h0011, 16'hffc3);
        set_row(1, 2, 16'h0033, 16'hfe9d, 16'h0101, 16'h0080);
        set_row(1, 3, 16'hff01, 16'h00ff, 16'hfffe, 16'h0003);
        set_vec(1, 16'h0143, 16'hfed7, 16'h0029, 16'hff81, 1'b0);
        // Small negative sums floor away from zero
        set_row(2, 0, 16'h0001, 16'h0000, 16'h0000, 16'h0000);
        set_row(2, 1, 16'hffff, 16'hffff, 16'h0000, 16'h0000);
        set_row(2, 2, 16'h0080, 16'h0000, 16'h0081, 16'h0000);
        set_row(2, 3, 16'h0000, 16'h0003, 16'h0000, 16'h0005);
        set_vec(2, 16'hffff, 16'h0001, 16'hff7f, 16'h0081, 1'b0);
        // Rows 0-1 clamp high, rows 2-3 clamp low
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                tab[3].a[r][c] = (r < 2) ? 16'h7fff : 16'h8000;
            end
        end
        set_vec(3, 16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff, 1'b1);
        // Back-to-back chain with i_dv held high
        for (int i = 4; i < N_DIRECTED; i++) begin
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    tab[i].a[r][c] = data_t'((r * 4 + c - 7) * 37 + i * 11);
                end
                tab[i].x[r] = data_t'((r - 1) * 300 - i * 19);
            end
            tab[i].hold_dv = (i < N_DIRECTED - 1);
        end
        for (int i = N_DIRECTED; i < N_ENTRIES; i++) begin
            for (int r = 0; r < DIM; r++) begin
                for (int c = 0; c < DIM; c++) begin
                    tab[i].a[r][c] = rand_elem(12);
                end
                tab[i].x[r] = rand_elem(12);
            end
            tab[i].hold_dv = (rand_bits(1) != 0);
        end
        for (int i = 0; i < N_ENTRIES; i++) begin
            exp_tab[i] = matvec_ref(tab[i].a, tab[i].x);
        end
    endfunction

    task automatic set_inputs(input mat_t a, input vec_t x);
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                i_a[r][c] = a[r][c];
            end
            i_x[r] = x[r];
        end
    endtask

    task automatic drive_junk();
        mat_t a;
        vec_t x;
        for (int r = 0; r < DIM; r++) begin
            for (int c = 0; c < DIM; c++) begin
                a[r][c] = rand_elem(16);
            end
            x[r] = rand_elem(16);
        end
        set_inputs(a, x);
    endtask

    // Called 2 ns after a rising edge, returns at the same offset
    task automatic apply_entry(input int idx);
        set_inputs(tab[idx].a, tab[idx].x);
        i_dv = 1'b1;
        do begin
            @(negedge clk);
        end while (!o_ready);
        @(posedge clk);
        #2;
        if (tab[idx].hold_dv && idx < N_ENTRIES - 1) begin
            return;
        end
        // Disturb operands and toggle i_dv while busy
        while (!o_ready) begin
            drive_junk();
            i_dv = !i_dv;
            @(posedge clk);
            #2;
        end
        i_dv = 1'b0;
        @(posedge clk);
        #2;
    endtask

    task automatic check_reset();
        assert (o_ready === 1'b1) else begin
            val_err++;
            $display("[ERROR] %0t o_ready: got %b expected 1", $time, o_ready);
        end
        assert (o_dv === 1'b0) else begin
            val_err++;
            $display("[ERROR] %0t o_dv: got %b expected 0", $time, o_dv);
        end
        for (int r = 0; r < DIM; r++) begin
            assert (o_y[r] === 16'h0000) else begin
                val_err++;
                $display("[ERROR] %0t o_y[%0d]: got %h expected 0000", $time, r, o_y[r]);
            end
        end
    endtask

    task automatic record_accept();
        int acc_edge;
        acc_edge = edge_cnt + 1;
        assert (acc_cnt < N_ENTRIES) else begin
            proto_err++;
            $display("Input accepted at %0t after the whole table was already taken", $time);
        end
        if (acc_cnt < N_ENTRIES) begin
            if (acc_cnt > 0 && tab[acc_cnt-1].hold_dv) begin
                assert (acc_edge - last_acc == ACCEPT_GAP) else begin
                    time_err++;
                    $display("[ERROR] %0t o_ready accept spacing: got %0d expected %0d",
                             $time, acc_edge - last_acc, ACCEPT_GAP);
                end
            end
            exp_q.push_back(exp_tab[acc_cnt]);
            due_q.push_back(acc_edge + LATENCY);
            last_acc = acc_edge;
            acc_cnt++;
        end
    endtask

    task automatic check_result();
        vec_t exp_y;
        int   due;
        assert (exp_q.size() > 0) else begin
            proto_err++;
            $display("o_dv pulsed at %0t with no accepted input waiting for a result", $time);
        end
        if (exp_q.size() > 0) begin
            exp_y = exp_q.pop_front();
            due   = due_q.pop_front();
            assert (edge_cnt == due) else begin
                time_err++;
                $display("[ERROR] %0t o_dv: got cycle %0d expected cycle %0d",
                         $time, edge_cnt, due);
            end
            for (int r = 0; r < DIM; r++) begin
                assert (o_y[r] == exp_y[r]) else begin
                    val_err++;
                    $display("[ERROR] %0t o_y[%0d]: got %h expected %h",
                             $time, r, o_y[r], exp_y[r]);
                end
            end
            done_cnt++;
        end
    endtask

    // Sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (rstn) begin
            if (o_dv) begin
                check_result();
            end
            if (i_dv && o_ready) begin
                record_accept();
            end
        end
    end

    initial begin
        rstn = 1'b0;
        i_dv = 1'b0;
        set_inputs('0, '0);
        build_table();
        repeat (2) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        check_reset();
        @(posedge clk);
        #2;
        for (int i = 0; i < N_ENTRIES; i++) begin
            apply_entry(i);
        end
        while (done_cnt < N_ENTRIES) begin
            @(posedge clk);
        end
        // Room for a stray strobe to show up
        repeat (8) @(posedge clk);
        $display("Errors: %0d value, %0d timing, %0d protocol", val_err, time_err, proto_err);
        if (val_err + time_err + proto_err == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+dv
hdl/mvm_num_pkg.sv
hdl/mvm_ctrl_pkg.sv
hdl/mvm_lane_if.sv
hdl/mvm_sequencer.sv
hdl/mvm_row_pair_mac.sv
hdl/mvm_result_merge.sv
hdl/mat_vec_mul_top.sv
dv/tb_mat_vec_mul.sv

// ==== Bender.yml ====
package:
  name: mat_vec_mul

sources:
  # Packages ahead of the interface and modules that import them
  - hdl/mvm_num_pkg.sv
  - hdl/mvm_ctrl_pkg.sv
  - hdl/mvm_lane_if.sv
  - hdl/mvm_sequencer.sv
  - hdl/mvm_row_pair_mac.sv
  - hdl/mvm_result_merge.sv
  - hdl/mat_vec_mul_top.sv

  # Testbench
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_mat_vec_mul.sv
